/* exec_ctrl_fsm.sv */
`timescale 1ns/1ps
module exec_ctrl_fsm (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_instr_valid,  // one-cycle strobe
    input  rv_pkg::dec_ctrl_t i_ctrl,
    input  logic              i_md_last,
    output logic              o_capture,
    output logic              o_busy,
    output logic              o_md_start,
    output logic              o_cnt_load,
    output logic              o_retire_valid,
    output logic              o_trap,
    output logic              o_commit
);

    rv_pkg::ctrl_state_e state, state_nxt;
    logic                md_go;

    // no data memory here, so loads and stores trap like unknown opcodes
    assign o_trap = ~i_ctrl.legal | (|i_ctrl.mem_op);
    assign md_go  = (state == rv_pkg::ST_EXEC) & i_ctrl.is_md & ~o_trap;

    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::ST_IDLE: begin
                if (i_instr_valid) begin
                    state_nxt = rv_pkg::ST_EXEC;
                end
            end
            rv_pkg::ST_EXEC: begin
                state_nxt = md_go ? rv_pkg::ST_MD_WAIT : rv_pkg::ST_RETIRE;
            end
            rv_pkg::ST_MD_WAIT: begin
                if (i_md_last) begin  // last iteration in flight
                    state_nxt = rv_pkg::ST_RETIRE;
                end
            end
            default: state_nxt = rv_pkg::ST_IDLE;  // retire lasts one cycle
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= rv_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_capture      = (state == rv_pkg::ST_IDLE) & i_instr_valid;  // busy strobes dropped
    assign o_busy         = (state != rv_pkg::ST_IDLE);
    assign o_md_start     = md_go;
    assign o_cnt_load     = md_go;  // counter and unit start together
    assign o_retire_valid = (state == rv_pkg::ST_RETIRE);
    assign o_commit       = (state == rv_pkg::ST_RETIRE);  // rf write + pc update

    // counter end only arrives while waiting on the unit
    a_md_last_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_md_last |-> state == rv_pkg::ST_MD_WAIT);

    // 32 iterations after the start
    a_md_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_md_start |-> ##32 i_md_last);

endmodule

/* exec_datapath.sv */
`timescale 1ns/1ps
module exec_datapath (
    input  logic [rv_pkg::XLEN-1:0] i_instr,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rs1,
    input  logic [rv_pkg::XLEN-1:0] i_rs2,
    input  rv_pkg::dec_ctrl_t       i_ctrl,
    input  logic [rv_pkg::XLEN-1:0] i_md_result,
    output logic [rv_pkg::XLEN-1:0] o_wb_data,
    output logic [rv_pkg::XLEN-1:0] o_next_pc
);

    localparam int W = rv_pkg::XLEN;

    logic [W-1:0] imm_i, imm_b, imm_j, op_b, alu_res;
    logic [W-1:0] base, offs, tgt_sum, pc4;
    logic         lt, ltu, eq, br_cond, taken;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        case (i_ctrl.b_sel)
            2'b01:   op_b = imm_i;
            2'b10:   op_b = {27'd0, i_instr[24:20]};  // shamt
            default: op_b = i_rs2;
        endcase
    end

    assign lt  = $signed(i_rs1) < $signed(op_b);
    assign ltu = i_rs1 < op_b;
    assign eq  = i_rs1 == op_b;

    always_comb begin
        case (i_ctrl.alu_fn)
            rv_pkg::ALU_ADD:  alu_res = i_rs1 + op_b;
            rv_pkg::ALU_SUB:  alu_res = i_rs1 - op_b;
            rv_pkg::ALU_SLL:  alu_res = i_rs1 << op_b[4:0];
            rv_pkg::ALU_SLT:  alu_res = {{(W-1){1'b0}}, lt};
            rv_pkg::ALU_SLTU: alu_res = {{(W-1){1'b0}}, ltu};
            rv_pkg::ALU_XOR:  alu_res = i_rs1 ^ op_b;
            rv_pkg::ALU_SRL:  alu_res = i_rs1 >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_res = $signed(i_rs1) >>> op_b[4:0];
            rv_pkg::ALU_OR:   alu_res = i_rs1 | op_b;
            rv_pkg::ALU_AND:  alu_res = i_rs1 & op_b;
            default:          alu_res = '0;  // bge / bgeu only compare
        endcase
    end

    // branch compare reuses the alu function code
    always_comb begin
        case (i_ctrl.alu_fn)
            rv_pkg::ALU_SUB:  br_cond = eq ^ i_ctrl.bneq;
            rv_pkg::ALU_SLT:  br_cond = lt;
            rv_pkg::ALU_SLTU: br_cond = ltu;
            rv_pkg::ALU_BGE:  br_cond = ~lt;
            rv_pkg::ALU_BGEU: br_cond = ~ltu;
            default:          br_cond = 1'b0;
        endcase
    end

    assign taken   = i_ctrl.pcselect[1] & (i_ctrl.j | i_ctrl.jr | (i_ctrl.btype & br_cond));
    assign base    = i_ctrl.pcselect[0] ? i_rs1 : i_pc;  // jalr is rs1 based
    assign offs    = i_ctrl.jr ? imm_i : (i_ctrl.j ? imm_j : imm_b);
    assign tgt_sum = base + offs;
    assign pc4     = i_pc + 32'd4;

    assign o_next_pc = taken ? {tgt_sum[W-1:1], tgt_sum[0] & ~i_ctrl.jr} : pc4;

    always_comb begin
        case (i_ctrl.wb_sel)
            rv_pkg::WB_PC4:  o_wb_data = pc4;  // link
            rv_pkg::WB_MD:   o_wb_data = i_md_result;
            rv_pkg::WB_LOAD: o_wb_data = '0;   // no load data, these trap
            default:         o_wb_data = alu_res;
        endcase
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps
module instr_decoder (
    input  logic [6:0]        i_op,
    input  logic [2:0]        i_funct3,
    input  logic [6:0]        i_funct7,
    input  logic              i_instr_30,  // instr[30], sub / sra select
    output rv_pkg::dec_ctrl_t o_ctrl
);

    logic is_r, is_i, is_br, is_jal, is_jalr, is_ld, is_st;
    logic r_base, r_md, i_shift, i_legal, br_legal, jalr_legal, ld_legal, st_legal;
    logic alt_ok;  // funct3 values that take the sub / sra form

    assign is_r    = (i_op == 7'b0110011);
    assign is_i    = (i_op == 7'b0010011);
    assign is_br   = (i_op == 7'b1100011);
    assign is_jal  = (i_op == 7'b1101111);
    assign is_jalr = (i_op == 7'b1100111);
    assign is_ld   = (i_op == 7'b0000011);
    assign is_st   = (i_op == 7'b0100011);

    assign alt_ok  = (i_funct3 == 3'd0) | (i_funct3 == 3'd5);

    // m-extension kept apart from the base r-type terms
    assign r_md    = is_r & (i_funct7 == 7'b0000001);
    assign r_base  = is_r & ((i_funct7 == 7'b0000000) | ((i_funct7 == 7'b0100000) & alt_ok));

    assign i_shift = is_i & ((i_funct3 == 3'd1) | (i_funct3 == 3'd5));
    assign i_legal = is_i & (~i_shift | (i_funct7 == 7'b0000000) |
                             ((i_funct3 == 3'd5) & (i_funct7 == 7'b0100000)));

    assign br_legal   = is_br & (i_funct3[2:1] != 2'b01);  // 2 and 3 are reserved
    assign jalr_legal = is_jalr & (i_funct3 == 3'd0);
    assign ld_legal   = is_ld & (i_funct3 != 3'd3) & (i_funct3 != 3'd6) & (i_funct3 != 3'd7);
    assign st_legal   = is_st & (i_funct3[2] == 1'b0) & (i_funct3 != 3'd3);

    always_comb begin
        o_ctrl          = '0;
        o_ctrl.pcselect = {is_br | is_jal | is_jalr, is_jalr};
        o_ctrl.we       = r_base | r_md | is_i | is_jal | is_jalr | is_ld;  // jalr local term
        o_ctrl.b_sel    = is_i ? (i_shift ? 2'b10 : 2'b01) : 2'b00;

        if (is_br) begin
            case (i_funct3)
                3'd4:    o_ctrl.alu_fn = rv_pkg::ALU_SLT;   // blt
                3'd5:    o_ctrl.alu_fn = rv_pkg::ALU_BGE;
                3'd6:    o_ctrl.alu_fn = rv_pkg::ALU_SLTU;  // bltu
                3'd7:    o_ctrl.alu_fn = rv_pkg::ALU_BGEU;
                default: o_ctrl.alu_fn = rv_pkg::ALU_SUB;   // beq / bne
            endcase
        end else if (r_base) begin
            o_ctrl.alu_fn = rv_pkg::alu_fn_e'({i_instr_30 & alt_ok, i_funct3});
        end else if (is_i) begin
            o_ctrl.alu_fn = rv_pkg::alu_fn_e'({i_instr_30 & (i_funct3 == 3'd5), i_funct3});
        end else begin
            o_ctrl.alu_fn = rv_pkg::ALU_ADD;
        end

        if (is_jal | is_jalr) begin
            o_ctrl.wb_sel = rv_pkg::WB_PC4;
        end else if (r_md) begin
            o_ctrl.wb_sel = rv_pkg::WB_MD;
        end else if (is_ld) begin
            o_ctrl.wb_sel = rv_pkg::WB_LOAD;
        end else begin
            o_ctrl.wb_sel = rv_pkg::WB_ALU;
        end

        o_ctrl.bneq  = is_br & (i_funct3 == 3'd1);
        o_ctrl.btype = is_br;
        o_ctrl.j     = is_jal;
        o_ctrl.jr    = is_jalr;
        // store, load, access size
        o_ctrl.mem_op = (is_ld | is_st) ? {is_st, is_ld, i_funct3[1:0]} : 4'd0;

        case (i_funct3)
            3'd0:    o_ctrl.m_op = rv_pkg::MD_MUL;
            3'd1:    o_ctrl.m_op = rv_pkg::MD_MULH;
            3'd2:    o_ctrl.m_op = rv_pkg::MD_MULHSU;
            3'd3:    o_ctrl.m_op = rv_pkg::MD_MULHU;
            3'd4:    o_ctrl.m_op = rv_pkg::MD_DIV;
            3'd5:    o_ctrl.m_op = rv_pkg::MD_DIVU;
            3'd6:    o_ctrl.m_op = rv_pkg::MD_REM;
            default: o_ctrl.m_op = rv_pkg::MD_REMU;
        endcase

        o_ctrl.is_md = r_md;
        o_ctrl.legal = r_base | r_md | i_legal | br_legal | is_jal | jalr_legal |
                       ld_legal | st_legal;
    end

endmodule

/* md_cycle_counter.sv */
`timescale 1ns/1ps
module md_cycle_counter (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_load,
    output logic o_last
);

    logic [4:0] cnt;
    logic       running;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (i_load) begin
            cnt     <= 5'd31;  // 32 iterations, last one seen at zero
            running <= 1'b1;
        end else if (running) begin
            if (cnt == 5'd0) begin
                running <= 1'b0;
            end else begin
                cnt <= cnt - 5'd1;
            end
        end
    end

    assign o_last = running & (cnt == 5'd0);

    // fsm waits for o_last, a reload mid-count would lose the running op
    a_no_reload: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load |-> !running);

endmodule

/* mul_div_unit.sv */
`timescale 1ns/1ps
module mul_div_unit (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  rv_pkg::md_op_e          i_op,
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    output logic [rv_pkg::XLEN-1:0] o_result  // held until the next start
);

    localparam int W = rv_pkg::XLEN;

    rv_pkg::md_op_e op_q;
    logic           sgn_a, sgn_b, running, last;
    logic [W-1:0]   mag_a, mag_b, rev_a;
    logic [W:0]     mark_q;               // sentinel on top, operand bits consumed lsb first
    logic [W-1:0]   opnd_q;               // multiplicand or divisor
    logic [W-1:0]   hi_q, lo_q, hi_nxt, lo_nxt;
    logic           neg_lo_q, neg_rem_q;  // product/quotient and remainder sign fix
    logic [W:0]     sum, shl;
    logic [W+1:0]   diff;
    logic [2*W-1:0] prod, prod_fix;
    logic [W-1:0]   res;

    // which operands count as signed
    assign sgn_a = i_a[W-1] & ((i_op == rv_pkg::MD_MULH) | (i_op == rv_pkg::MD_MULHSU) |
                               (i_op == rv_pkg::MD_DIV)  | (i_op == rv_pkg::MD_REM));
    assign sgn_b = i_b[W-1] & ((i_op == rv_pkg::MD_MULH) | (i_op == rv_pkg::MD_DIV) |
                               (i_op == rv_pkg::MD_REM));
    assign mag_a = sgn_a ? -i_a : i_a;
    assign mag_b = sgn_b ? -i_b : i_b;
    assign rev_a = {<<{mag_a}};  // dividend is consumed msb first

    assign running = |mark_q[W:1];
    assign last    = running & (mark_q[W:1] == 1);  // sentinel about to reach bit 0

    // one iteration: shift-add for mul, restoring subtract for div
    always_comb begin
        sum  = {1'b0, hi_q} + (mark_q[0] ? {1'b0, opnd_q} : '0);
        shl  = {hi_q, mark_q[0]};
        diff = {1'b0, shl} - {2'b0, opnd_q};
        if (op_q[2]) begin
            hi_nxt = diff[W+1] ? shl[W-1:0] : diff[W-1:0];  // restore on borrow
            lo_nxt = {lo_q[W-2:0], ~diff[W+1]};
        end else begin
            hi_nxt = sum[W:1];
            lo_nxt = {sum[0], lo_q[W-1:1]};
        end
    end

    // sign correction; min / -1 falls out as dividend with rem 0
    assign prod     = {hi_nxt, lo_nxt};
    assign prod_fix = neg_lo_q ? -prod : prod;

    always_comb begin
        case (op_q)
            rv_pkg::MD_MUL:                   res = prod_fix[W-1:0];
            rv_pkg::MD_DIV, rv_pkg::MD_DIVU:  res = neg_lo_q ? -lo_nxt : lo_nxt;
            rv_pkg::MD_REM, rv_pkg::MD_REMU:  res = neg_rem_q ? -hi_nxt : hi_nxt;
            default:                          res = prod_fix[2*W-1:W];  // mulh group
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mark_q <= '0;
        end else if (i_start) begin
            mark_q <= {1'b1, i_op[2] ? rev_a : mag_b};
        end else if (running) begin
            mark_q <= mark_q >> 1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            op_q      <= i_op;
            opnd_q    <= i_op[2] ? mag_b : mag_a;
            hi_q      <= '0;
            lo_q      <= '0;
            // div by zero keeps the all-ones quotient unsigned
            neg_lo_q  <= (sgn_a ^ sgn_b) & ~(i_op[2] & (i_b == '0));
            neg_rem_q <= sgn_a;  // remainder follows the dividend
        end else if (running) begin
            hi_q <= hi_nxt;
            lo_q <= lo_nxt;
            if (last) begin
                o_result <= res;
            end
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
module reg_file #(
    parameter int NUM_REGS = 32  // 16 for rv32e
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_we,
    input  logic [4:0]              i_rd,
    input  logic [rv_pkg::XLEN-1:0] i_wdata,
    input  logic [4:0]              i_rs1,
    input  logic [4:0]              i_rs2,
    output logic [rv_pkg::XLEN-1:0] o_rdata1,
    output logic [rv_pkg::XLEN-1:0] o_rdata2
);

    localparam int AW = $clog2(NUM_REGS);

    logic [rv_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_we && (i_rd != 5'd0) && (i_rd < NUM_REGS)) begin
            regs[i_rd[AW-1:0]] <= i_wdata;
        end
    end

    // x0 and out of range names read zero
    assign o_rdata1 = (i_rs1 == 5'd0 || i_rs1 >= NUM_REGS) ? '0 : regs[i_rs1[AW-1:0]];
    assign o_rdata2 = (i_rs2 == 5'd0 || i_rs2 >= NUM_REGS) ? '0 : regs[i_rs2[AW-1:0]];

    a_rd_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_we |-> i_rd < NUM_REGS);

endmodule

/* run.sh */
#!/bin/sh
# build and run the rv32im execution testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_rv_exec -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
fi
exit $status

/* rv_exec_top.sv */
`timescale 1ns/1ps
module rv_exec_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000,
    parameter int                      NUM_REGS = 32
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_instr_valid,
    input  logic [rv_pkg::XLEN-1:0] i_instr,
    output logic                    o_busy,
    output logic                    o_retire_valid,
    output rv_pkg::retire_t         o_retire,
    output logic [rv_pkg::XLEN-1:0] o_pc
);

    rv_pkg::dec_ctrl_t       ctrl;
    logic [rv_pkg::XLEN-1:0] ir;  // instruction register
    logic [rv_pkg::XLEN-1:0] rs1_data, rs2_data, wb_data, next_pc, md_result;
    logic                    capture, md_start, cnt_load, md_last, trap, commit;
    logic [4:0]              rd;

    always_ff @(posedge i_clk) begin
        if (capture) begin
            ir <= i_instr;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else if (commit) begin
            o_pc <= o_retire.next_pc;  // traps still step by 4
        end
    end

    assign rd = ir[11:7];

    always_comb begin
        o_retire.trap    = trap;
        o_retire.we      = ctrl.we & ~trap & (rd != 5'd0);  // x0 writes report we clear
        o_retire.rd      = rd;
        o_retire.data    = wb_data;
        o_retire.next_pc = next_pc;
    end

    instr_decoder u_dec (
        .i_op       (ir[6:0]),
        .i_funct3   (ir[14:12]),
        .i_funct7   (ir[31:25]),
        .i_instr_30 (ir[30]),
        .o_ctrl     (ctrl)
    );

    exec_ctrl_fsm u_fsm (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_ctrl         (ctrl),
        .i_md_last      (md_last),
        .o_capture      (capture),
        .o_busy         (o_busy),
        .o_md_start     (md_start),
        .o_cnt_load     (cnt_load),
        .o_retire_valid (o_retire_valid),
        .o_trap         (trap),
        .o_commit       (commit)
    );

    md_cycle_counter u_cnt (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_load  (cnt_load),
        .o_last  (md_last)
    );

    mul_div_unit u_md (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (md_start),
        .i_op     (ctrl.m_op),
        .i_a      (rs1_data),
        .i_b      (rs2_data),
        .o_result (md_result)
    );

    exec_datapath u_dp (
        .i_instr     (ir),
        .i_pc        (o_pc),
        .i_rs1       (rs1_data),
        .i_rs2       (rs2_data),
        .i_ctrl      (ctrl),
        .i_md_result (md_result),
        .o_wb_data   (wb_data),
        .o_next_pc   (next_pc)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_rf (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (commit & o_retire.we),
        .i_rd     (rd),
        .i_wdata  (wb_data),
        .i_rs1    (ir[19:15]),
        .i_rs2    (ir[24:20]),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

endmodule

/* rv_pkg.sv */
package rv_pkg;

    parameter int XLEN = 32;  // fixed by the ISA

    // alu / branch compare function, {instr[30], funct3} style codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,  // also blt
        ALU_SLTU = 4'b0011,  // also bltu
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,  // also beq / bne
        ALU_BGE  = 4'b1001,
        ALU_BGEU = 4'b1010,
        ALU_SRA  = 4'b1101
    } alu_fn_e;

    // m-extension op, bit 2 set for the divide group
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIVU   = 3'b100,
        MD_DIV    = 3'b101,
        MD_REMU   = 3'b110,
        MD_REM    = 3'b111
    } md_op_e;

    typedef enum logic [2:0] {
        WB_ALU  = 3'b000,
        WB_PC4  = 3'b001,  // link address for jal / jalr
        WB_MD   = 3'b010,
        WB_LOAD = 3'b100
    } wb_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_MD_WAIT,
        ST_RETIRE
    } ctrl_state_e;

    typedef struct packed {
        logic [1:0] pcselect;  // [1] control transfer, [0] rs1 based
        logic       we;
        logic [1:0] b_sel;     // 00 rs2, 01 imm, 10 shamt
        alu_fn_e    alu_fn;
        wb_sel_e    wb_sel;
        logic       bneq;
        logic       btype;
        logic       j;
        logic       jr;
        logic [3:0] mem_op;    // nonzero for loads and stores
        md_op_e     m_op;
        logic       is_md;
        logic       legal;
    } dec_ctrl_t;

    typedef struct packed {
        logic            trap;
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] next_pc;
    } retire_t;

endpackage

/* sources.f */
rv_pkg.sv
instr_decoder.sv
exec_ctrl_fsm.sv
md_cycle_counter.sv
mul_div_unit.sv
exec_datapath.sv
reg_file.sv
rv_exec_top.sv
tb_rv_exec.sv

/* tb_rv_exec.sv */
`timescale 1ns/1ps
module tb_rv_exec;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam logic [31:0] OP_IMM   = 32'h13;
    localparam logic [31:0] OP_REG   = 32'h33;

    logic                    clk;
    logic                    rst_n;
    logic                    i_instr_valid;
    logic [rv_pkg::XLEN-1:0] i_instr;
    logic                    o_busy;
    logic                    o_retire_valid;
    rv_pkg::retire_t         o_retire;
    logic [rv_pkg::XLEN-1:0] o_pc;

    rv_pkg::retire_t want;     // expected retire report of the instruction in flight
    logic            pending;  // an accepted instruction has not retired yet
    logic [31:0]     model_rf [32];
    logic [31:0]     model_pc;
    logic [15:0]     lfsr;

    rv_exec_top #(
        .RESET_PC (RESET_PC),
        .NUM_REGS (32)
    ) rv_exec_top_inst (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_busy         (o_busy),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire),
        .o_pc           (o_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic fail_stop(input string what);
        $display("error: %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp_v);
        $display("mismatch %s: got %h expected %h", name, got, exp_v);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] rnd_reg();
        logic [31:0] r;
        r = rand_bits(4);
        return (r == 0) ? 32'd1 : r;  // x1..x15, all written first
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd, op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // integer ops by funct3, alt picks sub / sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] md_ref(input logic [2:0] f3, input logic [31:0] a, b);
        logic [63:0]        p;
        logic               ovf;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        sq  = '0;
        sr  = '0;
        if (b != 0 && !ovf) begin
            sq = $signed(a) / $signed(b);  // truncates toward zero
            sr = $signed(a) % $signed(b);
        end
        case (f3)
            3'd0: p = {32'd0, a} * {32'd0, b};
            3'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            3'd2: p = {{32{a[31]}}, a} * {32'd0, b};  // mulhsu
            default: p = {32'd0, a} * {32'd0, b};
        endcase
        case (f3)
            3'd0: return p[31:0];
            3'd1, 3'd2, 3'd3: return p[63:32];
            3'd4: return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
            3'd5: return (b == 0) ? 32'hffff_ffff : a / b;
            3'd6: return (b == 0) ? a : (ovf ? 32'd0 : sr);
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    // expected retire report from the model state
    function automatic rv_pkg::retire_t predict(input logic [31:0] ins);
        rv_pkg::retire_t r;
        logic [31:0]     a, b, imm_i, imm_b, imm_j;
        logic [2:0]      f3;
        logic            cond;
        a     = model_rf[ins[19:15]];
        b     = model_rf[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        r.trap    = 1'b0;
        r.we      = 1'b1;
        r.rd      = ins[11:7];
        r.data    = '0;
        r.next_pc = model_pc + 32'd4;
        case (ins[6:0])
            7'h13: r.data = alu_ref(f3, (f3 == 3'd5) & ins[30], a, imm_i);
            7'h33: r.data = (ins[25]) ? md_ref(f3, a, b) : alu_ref(f3, ins[30], a, b);
            7'h63: begin
                case (f3)
                    3'd0: cond = a == b;
                    3'd1: cond = a != b;
                    3'd4: cond = $signed(a) < $signed(b);
                    3'd5: cond = $signed(a) >= $signed(b);
                    3'd6: cond = a < b;
                    default: cond = a >= b;
                endcase
                r.we = 1'b0;
                if (cond) r.next_pc = model_pc + imm_b;
            end
            7'h6f: begin
                r.data    = model_pc + 32'd4;
                r.next_pc = model_pc + imm_j;
            end
            7'h67: begin
                r.data    = model_pc + 32'd4;
                r.next_pc = (a + imm_i) & 32'hffff_fffe;
            end
            default: begin  // loads, stores, unknown opcodes
                r.trap = 1'b1;
                r.we   = 1'b0;
            end
        endcase
        if (r.rd == 5'd0) r.we = 1'b0;
        return r;
    endfunction

    // send one instruction, wait for its retire and update the model
    task automatic issue(input logic [31:0] ins, input bit poke);
        int t;
        bit done;
        done = 1'b0;
        @(negedge clk);
        assert (o_pc == model_pc) else mismatch("o_pc", o_pc, model_pc);
        assert (!o_busy) else fail_stop("o_busy high before a new instruction");
        @(posedge clk);
        want          <= predict(ins);
        pending       <= 1'b1;
        i_instr_valid <= 1'b1;
        i_instr       <= ins;
        @(posedge clk);
        i_instr_valid <= 1'b0;
        for (t = 0; t < 100 && !done; t++) begin
            @(negedge clk);
            if (o_retire_valid) begin
                done = 1'b1;
            end else if (poke && t == 3) begin
                @(posedge clk);
                i_instr_valid <= 1'b1;  // dut is busy, must be dropped
                i_instr       <= enc_i(1, 0, 0, 5, OP_IMM);
                @(posedge clk);
                i_instr_valid <= 1'b0;
            end
        end
        if (!done) fail_stop("timeout waiting for o_retire_valid");
        if (want.we) model_rf[want.rd] = want.data;
        model_pc = want.next_pc;
        @(posedge clk);
        pending <= 1'b0;
    endtask

    a_trap: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid |-> o_retire.trap == want.trap)
        else mismatch("o_retire.trap", {31'd0, $sampled(o_retire.trap)},
                      {31'd0, $sampled(want.trap)});
    a_we: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid |-> o_retire.we == want.we)
        else mismatch("o_retire.we", {31'd0, $sampled(o_retire.we)},
                      {31'd0, $sampled(want.we)});
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid |-> o_retire.rd == want.rd)
        else mismatch("o_retire.rd", {27'd0, $sampled(o_retire.rd)},
                      {27'd0, $sampled(want.rd)});
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid && want.we |-> o_retire.data == want.data)
        else mismatch("o_retire.data", $sampled(o_retire.data), $sampled(want.data));
    a_next_pc: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid |-> o_retire.next_pc == want.next_pc)
        else mismatch("o_retire.next_pc", $sampled(o_retire.next_pc),
                      $sampled(want.next_pc));
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        o_retire_valid |-> pending)
        else fail_stop("retire without an accepted instruction");
    // busy only drops after the retire cycle
    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(o_busy) |-> $past(o_retire_valid))
        else fail_stop("o_busy dropped before retire");

    initial begin
        int          r;
        int          k;
        int          f3;
        int          alt;
        int          p;
        logic [31:0] imm;
        rst_n         = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        pending       = 1'b0;
        want          = '0;
        lfsr          = 16'd64371;
        model_pc      = RESET_PC;
        for (r = 0; r < 32; r++) model_rf[r] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (o_pc == RESET_PC) else mismatch("o_pc", o_pc, RESET_PC);
        assert (!o_busy && !o_retire_valid) else fail_stop("busy or retire high after reset");

        // random register contents from addi / slli / xori chains
        for (r = 1; r < 16; r++) begin
            issue(enc_i(rand_bits(12), 0, 0, r, OP_IMM), 0);
            issue(enc_i(11, r, 1, r, OP_IMM), 0);
            issue(enc_i(rand_bits(12), r, 4, r, OP_IMM), 0);
            issue(enc_i(10, r, 1, r, OP_IMM), 0);
            issue(enc_i(rand_bits(12), r, 4, r, OP_IMM), 0);
        end

        // every r-type and i-type alu op
        for (k = 0; k < 3; k++) begin
            for (f3 = 0; f3 < 8; f3++) begin
                for (alt = 0; alt < 2; alt++) begin
                    if (alt == 0 || f3 == 0 || f3 == 5) begin
                        issue(enc_r(alt * 32, rnd_reg(), rnd_reg(), f3, rnd_reg(), OP_REG), 0);
                    end
                    if (alt == 0 || f3 == 5) begin
                        if (f3 == 1 || f3 == 5) imm = alt * 1024 + rand_bits(5);  // shamt
                        else imm = rand_bits(12);
                        issue(enc_i(imm, rnd_reg(), f3, rnd_reg(), OP_IMM), 0);
                    end
                end
            end
        end

        // m ops, first one with a strobe during busy
        issue(enc_r(1, 2, 1, 4, 3, OP_REG), 1);
        repeat (3) begin
            @(negedge clk);
            assert (!o_busy && !o_retire_valid) else fail_stop("dropped strobe was executed");
        end
        for (k = 0; k < 3; k++) begin
            for (f3 = 0; f3 < 8; f3++) begin
                issue(enc_r(1, rnd_reg(), rnd_reg(), f3, rnd_reg(), OP_REG), 0);
            end
        end
        issue(enc_i(1, 0, 0, 10, OP_IMM), 0);       // x10 = 0x80000000
        issue(enc_i(31, 10, 1, 10, OP_IMM), 0);
        issue(enc_i(12'hfff, 0, 0, 11, OP_IMM), 0); // x11 = -1
        for (f3 = 4; f3 < 8; f3++) begin
            issue(enc_r(1, 0, 3, f3, 12, OP_REG), 0);   // divide by zero
            issue(enc_r(1, 11, 10, f3, 13, OP_REG), 0); // overflow
        end

        // branches both ways, then jal / jalr
        for (f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                for (p = 0; p < 3; p++) begin
                    imm = {19'd0, rand_bits(1) ? 6'h3f : 6'h00, rand_bits(6), 1'b0};
                    issue(enc_b(imm, (p == 1) ? 2 : 1, (p == 2) ? 2 : 1, f3), 0);
                end
            end
        end
        for (k = 0; k < 4; k++) begin
            imm = {11'd0, rand_bits(1) ? 9'h1ff : 9'h000, rand_bits(11), 1'b0};
            issue(enc_j(imm, rnd_reg()), 0);
            issue(enc_i(rand_bits(12), rnd_reg(), 0, rnd_reg(), 32'h67), 0);
        end

        // traps leave x7 alone
        issue(enc_i(12'h010, 1, 2, 7, 32'h03), 0);  // lw
        issue({7'd0, 5'd2, 5'd1, 3'd2, 5'd7, 7'h23}, 0);  // sw
        issue(enc_i(12'h123, 1, 0, 7, 32'h0b), 0);  // custom-0
        issue(enc_r(0, 0, 7, 0, 8, OP_REG), 0);

        // x0 stays zero
        issue(enc_i(12'h055, 1, 0, 0, OP_IMM), 0);
        issue(enc_r(0, 0, 0, 0, 9, OP_REG), 0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
